//--- filelist.f
+incdir+src
src/wfd_bus_pkg.sv
src/wfd_daq_pkg.sv
src/wfd_ctrl_regs.sv
src/trigger_queue.sv
src/event_builder.sv
src/wfd_top.sv
tests/wfd_props.sv
tests/wfd_tb.sv

//--- Makefile
SIM  := obj_dir/Vwfd_tb
SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module wfd_tb -o Vwfd_tb

clean:
	rm -rf obj_dir

//--- tests/wfd_tb.sv
`timescale 1ns/10ps
`include "wfd_settings.svh"

module wfd_tb
    import wfd_bus_pkg::*;
    import wfd_daq_pkg::*;
();

    localparam int BUS_TIMEOUT   = 16;      // cycles allowed for wb_ack
    localparam int DRAIN_TIMEOUT = 20000;   // cycles allowed for all pending words
    localparam int NUM_EVENTS    = 40;
    localparam int BURST         = 8;       // more triggers than builder plus queue hold

    logic       clk125;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_wdata;
    wb_data_t   wb_rdata;
    logic       wb_ack;
    chan_mask_t chan_trigs;
    logic       daq_valid;
    logic       daq_header;
    logic       daq_trailer;
    daq_word_t  daq_data;
    logic       daq_ready;
    logic       daq_almost_full;

    int         seed = 32'hfc26_d275;
    daq_word_t  exp_words[$];   // words still due on the link
    logic [1:0] exp_flags[$];   // {header, trailer} for each due word
    evt_num_t   next_num;       // number of the next accepted event
    wb_data_t   acc_cnt;
    wb_data_t   drop_cnt;
    int         trl_seen;       // trailers already seen on the link
    logic       hold_full;      // overflow phase pins almost_full high
    daq_word_t  mon_word;
    logic [1:0] mon_flags;

    wfd_top u_wfd_top (.*);

    initial clk125 = 1'b0;
    always #10 clk125 = ~clk125;   // 20 ns

    // link status with ready mostly high
    always @(posedge clk125) begin
        daq_ready       <= ($random(seed) & 7) != 0;
        daq_almost_full <= hold_full || (($random(seed) & 3) == 0);
    end

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input daq_word_t got, input daq_word_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_rdata(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // one classic cycle that returns on the edge dropping the strobe
    task automatic bus_cycle(input wb_addr_t adr, input wb_data_t data, input logic we,
                             output wb_data_t rdata);
        int n;
        @(posedge clk125);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= data;
        n = 0;
        do begin
            @(negedge clk125);
            n++;
            if (n > BUS_TIMEOUT) begin
                $display("timeout: no wb_ack for address %h", adr);
                stop_on_error();
            end
        end while (!wb_ack);
        rdata = wb_rdata;   // valid while ack is high
        @(posedge clk125);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(adr, data, 1'b1, unused);
    endtask

    task automatic bus_read_check(input wb_addr_t adr, input wb_data_t exp);
        wb_data_t got;
        bus_cycle(adr, '0, 1'b0, got);
        check_rdata("wb_rdata", got, exp);
    endtask

    // expected words of one event built from the link format
    task automatic push_event(input evt_num_t num, input chan_mask_t mask, input evt_len_t len);
        daq_word_t   w;
        logic [31:0] sum;
        sum = '0;
        w = '0;
        w[63:56] = `WFD_HDR_MARK;
        w[55:48] = 8'(mask);
        w[47:40] = len;
        w[23:0]  = num;
        exp_words.push_back(w);
        exp_flags.push_back(2'b10);
        for (int i = 0; i < int'(len); i++) begin
            w[63:32] = 32'(num);
            w[31:0]  = 32'(i);
            sum = sum ^ w[63:32] ^ w[31:0];
            exp_words.push_back(w);
            exp_flags.push_back(2'b00);
        end
        w[63:56] = `WFD_TRL_MARK;
        w[55:32] = num;
        w[31:0]  = sum;   // zero for an empty event
        exp_words.push_back(w);
        exp_flags.push_back(2'b01);
    endtask

    // trigger write whose pulse one cycle after the ack tells accept from drop
    task automatic send_trigger(input chan_mask_t mask, input evt_len_t len, output logic acc);
        bus_write(`WFD_REG_TRIGGER, 32'h1);
        @(negedge clk125);
        if (mask == '0 || chan_trigs != '0) begin
            check_mask("chan_trigs", chan_trigs, mask);
        end
        acc = (mask != '0) && (chan_trigs == mask);
        // fewer unfinished events than queue entries means there was room
        if (mask != '0 && !acc && (int'(acc_cnt) - trl_seen) < `WFD_QUEUE_DEPTH) begin
            $display("trigger dropped although the queue had room");
            stop_on_error();
        end
        if (acc) begin
            push_event(next_num, mask, len);
            next_num = next_num + 1'b1;
            acc_cnt  = acc_cnt + 1;
        end else if (mask != '0) begin
            drop_cnt = drop_cnt + 1;   // queue was full
        end
        @(negedge clk125);
        check_mask("chan_trigs", chan_trigs, '0);   // single cycle pulse
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_words.size() != 0) begin
            @(negedge clk125);
            n++;
            if (n > DRAIN_TIMEOUT) begin
                $display("timeout: %0d expected DAQ words never arrived", exp_words.size());
                stop_on_error();
            end
        end
    endtask

    // link monitor sampling after the outputs settle
    always @(negedge clk125) begin
        if (arst_n && daq_valid) begin
            if (exp_words.size() == 0) begin
                $display("unexpected DAQ word %h with no event pending", daq_data);
                stop_on_error();
            end
            mon_word  = exp_words.pop_front();
            mon_flags = exp_flags.pop_front();
            check_word("daq_data", daq_data, mon_word);
            check_flag("daq_header", daq_header, mon_flags[1]);
            check_flag("daq_trailer", daq_trailer, mon_flags[0]);
            if (mon_flags[0]) begin
                trl_seen++;   // event has left the queue for good
            end
        end
    end

    initial begin
        wb_data_t   data;
        chan_mask_t mask;
        evt_len_t   len;
        logic       acc;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_wdata        = '0;
        daq_ready       = 1'b1;
        daq_almost_full = 1'b0;
        arst_n          = 1'b0;
        hold_full       = 1'b0;
        next_num        = '0;
        acc_cnt         = '0;
        drop_cnt        = '0;
        trl_seen        = 0;
        repeat (4) @(posedge clk125);
        arst_n <= 1'b1;
        @(negedge clk125);
        check_flag("wb_ack", wb_ack, 1'b0);
        check_mask("chan_trigs", chan_trigs, '0);
        check_flag("daq_valid", daq_valid, 1'b0);
        check_flag("daq_header", daq_header, 1'b0);
        check_flag("daq_trailer", daq_trailer, 1'b0);

        // register map
        data = $random(seed);
        bus_write(`WFD_REG_CTRL, data);
        bus_read_check(`WFD_REG_CTRL, wb_data_t'(data[`WFD_NUM_CHAN-1:0]));
        @(negedge clk125);
        data = $random(seed);
        bus_write(`WFD_REG_LENGTH, data);
        bus_read_check(`WFD_REG_LENGTH, wb_data_t'(data[7:0]));
        bus_write(`WFD_REG_COUNT, 32'hffff_ffff);   // read only so ignored
        bus_read_check(`WFD_REG_COUNT, '0);
        bus_read_check(`WFD_REG_DROPS, '0);
        bus_read_check(`WFD_REG_TRIGGER, '0);
        for (int a = 5; a < 16; a++) begin
            bus_read_check(wb_addr_t'(a), '0);
        end

        // disabled channels give no pulse and no event
        bus_write(`WFD_REG_CTRL, '0);
        send_trigger('0, evt_len_t'(data[7:0]), acc);

        // random events under random back-pressure
        for (int i = 0; i < NUM_EVENTS; i++) begin
            data = $random(seed);
            mask = data[`WFD_NUM_CHAN-1:0];
            if (data[31:29] == 3'b000) begin
                mask = '0;
            end
            case (data[28:26])
                3'd0:    len = 8'd0;
                3'd1:    len = 8'd255;
                default: len = evt_len_t'(data[13:8]);   // mostly short events
            endcase
            bus_write(`WFD_REG_CTRL, wb_data_t'(mask));
            bus_write(`WFD_REG_LENGTH, wb_data_t'(len));
            send_trigger(mask, len, acc);
        end
        wait_drain();

        // overflow with one event in the builder and the queue filling behind it
        hold_full = 1'b1;
        data = $random(seed);
        mask = data[`WFD_NUM_CHAN-1:0] | 5'h01;
        bus_write(`WFD_REG_CTRL, wb_data_t'(mask));
        bus_write(`WFD_REG_LENGTH, 32'd3);
        for (int i = 0; i < BURST; i++) begin
            send_trigger(mask, 8'd3, acc);
            if (acc != (i < `WFD_QUEUE_DEPTH + 1)) begin
                $display("overflow trigger %0d was accepted %0d, queue depth not honoured",
                         i, acc);
                stop_on_error();
            end
        end
        bus_read_check(`WFD_REG_COUNT, acc_cnt);
        bus_read_check(`WFD_REG_DROPS, drop_cnt);
        hold_full <= 1'b0;
        wait_drain();
        repeat (50) @(posedge clk125);   // quiet link where a stray word trips the monitor

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tests/wfd_props.sv
`timescale 1ns/10ps

module wfd_props (
    input logic clk125,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic daq_valid,
    input logic daq_header,
    input logic daq_trailer,
    input logic daq_ready,
    input logic daq_almost_full
);

    // ack only answers a live strobe
    ack_in_cycle: assert property (@(posedge clk125) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high outside a bus cycle");

    // markers ride on valid words
    marks_need_valid: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_header || daq_trailer) |-> daq_valid)
        else $error("daq_header or daq_trailer without daq_valid");

    marks_exclusive: assert property (@(posedge clk125) disable iff (!arst_n)
        !(daq_header && daq_trailer))
        else $error("daq_header and daq_trailer together");

    // link status of the previous cycle gates every word
    stall_rule: assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid |-> $past(daq_ready && !daq_almost_full))
        else $error("daq_valid after a stalled cycle");

endmodule

bind wfd_top wfd_props u_wfd_props (.*);

//--- src/wfd_top.sv
`timescale 1ns/10ps

module wfd_top
    import wfd_bus_pkg::*;
    import wfd_daq_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    // host register bus
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_wdata,
    output wb_data_t   wb_rdata,
    output logic       wb_ack,
    // digitizer channel triggers
    output chan_mask_t chan_trigs,
    // daq link
    output logic       daq_valid,
    output logic       daq_header,
    output logic       daq_trailer,
    output daq_word_t  daq_data,
    input  logic       daq_ready,
    input  logic       daq_almost_full
);

    logic       trig_req;
    chan_mask_t en_mask;
    evt_len_t   evt_len;
    evt_num_t   evt_count;
    wb_data_t   drop_count;
    logic       q_valid;
    evt_num_t   q_num;
    chan_mask_t q_mask;
    evt_len_t   q_len;
    logic       q_pop;

    // host registers
    wfd_ctrl_regs u_ctrl_regs (
        .clk125(clk125), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .trig_req(trig_req), .en_mask(en_mask), .evt_len(evt_len),
        .evt_count(evt_count), .drop_count(drop_count)
    );

    // trigger acceptance and pending events
    trigger_queue u_trigger_queue (
        .clk125(clk125), .arst_n(arst_n),
        .trig_req(trig_req), .en_mask(en_mask), .evt_len(evt_len),
        .chan_trigs(chan_trigs),
        .evt_count(evt_count), .drop_count(drop_count),
        .q_valid(q_valid), .q_num(q_num), .q_mask(q_mask), .q_len(q_len),
        .q_pop(q_pop)
    );

    // formatting onto the daq link
    event_builder u_event_builder (
        .clk125(clk125), .arst_n(arst_n),
        .q_valid(q_valid), .q_num(q_num), .q_mask(q_mask), .q_len(q_len),
        .q_pop(q_pop),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data),
        .daq_ready(daq_ready), .daq_almost_full(daq_almost_full)
    );

endmodule

//--- src/event_builder.sv
`timescale 1ns/10ps
`include "wfd_settings.svh"

module event_builder
    import wfd_daq_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    // queue side
    input  logic       q_valid,
    input  evt_num_t   q_num,
    input  chan_mask_t q_mask,
    input  evt_len_t   q_len,
    output logic       q_pop,
    // daq link
    output logic       daq_valid,
    output logic       daq_header,
    output logic       daq_trailer,
    output daq_word_t  daq_data,
    input  logic       daq_ready,
    input  logic       daq_almost_full
);

    builder_state_t state;
    logic           link_ok;   // link status from the previous cycle
    evt_len_t       word_idx;  // payload word being offered
    evt_num_t       ev_num;    // event taken from the queue
    chan_mask_t     ev_mask;
    evt_len_t       ev_len;
    logic [31:0]    csum;      // running xor over payload halves
    logic [31:0]    pay_hi;
    logic [31:0]    pay_lo;
    logic           emit;      // a word goes out this cycle

    assign q_pop = (state == ST_IDLE) && q_valid;

    assign pay_hi = 32'(ev_num);
    assign pay_lo = 32'(word_idx);
    assign emit   = (state != ST_IDLE) && link_ok;

    // word on the link, held while stalled
    always_comb begin
        case (state)
            ST_HEADER:  daq_data = {`WFD_HDR_MARK, 8'(ev_mask), ev_len, 16'h0000, ev_num};
            ST_PAYLOAD: daq_data = {pay_hi, pay_lo};
            ST_TRAILER: daq_data = {`WFD_TRL_MARK, ev_num, csum};
            default:    daq_data = '0;
        endcase
    end

    assign daq_valid   = emit;
    assign daq_header  = emit && (state == ST_HEADER);
    assign daq_trailer = emit && (state == ST_TRAILER);

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            link_ok  <= 1'b0;
            word_idx <= '0;
        end else begin
            link_ok <= daq_ready && !daq_almost_full;   // registered, so valid lags status by one
            case (state)
                ST_IDLE: begin
                    word_idx <= '0;
                    if (q_valid) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (link_ok) begin
                        state <= (ev_len == '0) ? ST_TRAILER : ST_PAYLOAD;   // empty event
                    end
                end
                ST_PAYLOAD: begin
                    if (link_ok) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == ev_len - 1'b1) begin
                            state <= ST_TRAILER;
                        end
                    end
                end
                ST_TRAILER: begin
                    if (link_ok) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // event fields and checksum
    always_ff @(posedge clk125) begin
        if (q_pop) begin
            ev_num  <= q_num;
            ev_mask <= q_mask;
            ev_len  <= q_len;
            csum    <= '0;   // stays zero for a zero length event
        end else if (emit && (state == ST_PAYLOAD)) begin
            csum <= csum ^ pay_hi ^ pay_lo;
        end
    end

endmodule

//--- src/trigger_queue.sv
`timescale 1ns/10ps
`include "wfd_settings.svh"

module trigger_queue
    import wfd_bus_pkg::*;
    import wfd_daq_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    // request from the register block
    input  logic       trig_req,
    input  chan_mask_t en_mask,
    input  evt_len_t   evt_len,
    // one cycle pulse to each enabled channel
    output chan_mask_t chan_trigs,
    // status counters
    output evt_num_t   evt_count,
    output wb_data_t   drop_count,
    // oldest pending event
    output logic       q_valid,
    output evt_num_t   q_num,
    output chan_mask_t q_mask,
    output evt_len_t   q_len,
    input  logic       q_pop
);

    localparam int PTR_W = $clog2(`WFD_QUEUE_DEPTH);

    // event storage, one entry per pending trigger
    evt_num_t   num_mem  [`WFD_QUEUE_DEPTH];
    chan_mask_t mask_mem [`WFD_QUEUE_DEPTH];
    evt_len_t   len_mem  [`WFD_QUEUE_DEPTH];

    logic [PTR_W:0] wr_ptr;   // extra msb tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic           q_full;
    logic           q_empty;
    logic           mask_on;
    logic           accept;
    logic           drop;
    logic           pop;

    assign q_empty = (wr_ptr == rd_ptr);
    assign q_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // zero mask means no channel would fire, so the trigger is ignored outright
    assign mask_on = (en_mask != '0);
    assign accept  = trig_req && mask_on && !q_full;
    assign drop    = trig_req && mask_on && q_full;   // a pop in the same cycle does not help
    assign pop     = q_valid && q_pop;

    assign q_valid = !q_empty;
    assign q_num   = num_mem[rd_ptr[PTR_W-1:0]];
    assign q_mask  = mask_mem[rd_ptr[PTR_W-1:0]];
    assign q_len   = len_mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            chan_trigs <= '0;
            evt_count  <= '0;
            drop_count <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            chan_trigs <= accept ? en_mask : '0;   // fan out, cycle after the ack
            if (accept) begin
                evt_count <= evt_count + 1'b1;   // wraps with the event number
                wr_ptr    <= wr_ptr + 1'b1;
            end
            if (drop) begin
                drop_count <= drop_count + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // snapshot of mask and length, numbered by the running count
    always_ff @(posedge clk125) begin
        if (accept) begin
            num_mem[wr_ptr[PTR_W-1:0]]  <= evt_count;
            mask_mem[wr_ptr[PTR_W-1:0]] <= en_mask;
            len_mem[wr_ptr[PTR_W-1:0]]  <= evt_len;
        end
    end

endmodule

//--- src/wfd_ctrl_regs.sv
`timescale 1ns/10ps
`include "wfd_settings.svh"

module wfd_ctrl_regs
    import wfd_bus_pkg::*;
    import wfd_daq_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    // wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_addr_t   wb_adr,
    input  wb_data_t   wb_wdata,
    output wb_data_t   wb_rdata,
    output logic       wb_ack,
    // towards trigger_queue
    output logic       trig_req,
    output chan_mask_t en_mask,
    output evt_len_t   evt_len,
    // status back from trigger_queue
    input  evt_num_t   evt_count,
    input  wb_data_t   drop_count
);

    logic     bus_req;   // first cycle of a strobe, ack not yet given
    logic     wr_en;
    logic     rd_en;
    wb_data_t rd_mux;

    // ack drops out after one cycle even if the master holds stb
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_en   = bus_req && wb_we;
    assign rd_en   = bus_req && !wb_we;

    // read decode, trigger and unmapped words give zero
    always_comb begin
        case (wb_adr)
            `WFD_REG_CTRL:   rd_mux = wb_data_t'(en_mask);
            `WFD_REG_LENGTH: rd_mux = wb_data_t'(evt_len);
            `WFD_REG_COUNT:  rd_mux = wb_data_t'(evt_count);   // zero extended
            `WFD_REG_DROPS:  rd_mux = drop_count;
            default:         rd_mux = '0;
        endcase
    end

    // control registers and handshake
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            trig_req <= 1'b0;
            en_mask  <= '0;
            evt_len  <= '0;
        end else begin
            wb_ack   <= bus_req;   // one cycle after strobe seen
            trig_req <= wr_en && (wb_adr == `WFD_REG_TRIGGER);   // pulses with the ack
            if (wr_en) begin
                case (wb_adr)
                    `WFD_REG_CTRL:   en_mask <= wb_wdata[`WFD_NUM_CHAN-1:0];
                    `WFD_REG_LENGTH: evt_len <= wb_wdata[`WFD_LEN_W-1:0];
                    default: ;   // read only and unmapped words ignore writes
                endcase
            end
        end
    end

    // read data captured on the edge that raises ack
    always_ff @(posedge clk125) begin
        if (rd_en) begin
            wb_rdata <= rd_mux;
        end else if (wr_en) begin
            wb_rdata <= '0;   // nothing meaningful on a write ack
        end
    end

endmodule

//--- src/wfd_daq_pkg.sv
`include "wfd_settings.svh"

// event and daq link types
package wfd_daq_pkg;

    typedef logic [`WFD_NUM_CHAN-1:0]  chan_mask_t;  // one bit per channel
    typedef logic [`WFD_LEN_W-1:0]     evt_len_t;    // payload words per event
    typedef logic [`WFD_EVT_NUM_W-1:0] evt_num_t;    // running event number
    typedef logic [`WFD_DAQ_W-1:0]     daq_word_t;   // one word on the link

    // builder fsm
    // header, payload and trailer each hold their word until the link allows it
    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for a queued event
        ST_HEADER,   // marker, mask, length, number
        ST_PAYLOAD,  // length words of fake data
        ST_TRAILER   // marker, number, checksum
    } builder_state_t;

endpackage

//--- src/wfd_bus_pkg.sv
`include "wfd_settings.svh"

// register bus types
package wfd_bus_pkg;

    // word address on the wishbone side
    typedef logic [`WFD_WB_ADDR_W-1:0] wb_addr_t;

    // read and write data, also used for wide status counters
    typedef logic [`WFD_WB_DATA_W-1:0] wb_data_t;

endpackage

//--- src/wfd_settings.svh
`ifndef WFD_SETTINGS_SVH
`define WFD_SETTINGS_SVH

// channel count and field widths
`define WFD_NUM_CHAN    5           // digitizer channels fed by chan_trigs
`define WFD_WB_ADDR_W   4           // register bus word address
`define WFD_WB_DATA_W   32
`define WFD_LEN_W       8           // payload length field, 0 allowed
`define WFD_EVT_NUM_W   24          // event number, wraps
`define WFD_DAQ_W       64          // daq link word

// pending events, keep a power of two
`define WFD_QUEUE_DEPTH 4

// register word addresses
`define WFD_REG_CTRL    4'h0        // enable mask, r/w
`define WFD_REG_LENGTH  4'h1        // payload length, r/w
`define WFD_REG_TRIGGER 4'h2        // software trigger, write only
`define WFD_REG_COUNT   4'h3        // accepted events, read only
`define WFD_REG_DROPS   4'h4        // dropped triggers, read only

// markers in the top byte of header and trailer
`define WFD_HDR_MARK    8'hA5
`define WFD_TRL_MARK    8'h5A

`endif
